// File: Makefile
SRCS := common/rv_pkg.sv verilog/rv_decoder.sv verilog/rv_regfile.sv \
	verilog/rv_execute.sv umem/umem_axi.sv verilog/rv_core.sv \
	tests/axil_mem_model.sv tests/rv_core_tb.sv

.PHONY: all run clean

all: run

obj_dir/Vrv_core_tb: rv_core.f $(SRCS)
	verilator --binary --timing -f rv_core.f --top-module rv_core_tb -Mdir obj_dir

run: obj_dir/Vrv_core_tb
	./obj_dir/Vrv_core_tb | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: common/rv_pkg.sv
`default_nettype none

package rv_pkg;

	// Every RV32I operation the core recognises, plus a catch-all no-op
	typedef enum logic [5:0] {
		OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
		OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
		OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
		OP_SB, OP_SH, OP_SW,
		OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
		OP_SLLI, OP_SRLI, OP_SRAI,
		OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
		OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
		OP_FENCE, OP_ECALL, OP_EBREAK,
		OP_NOP
	} rv_op_e;

	typedef enum logic [1:0] {
		SZ_BYTE,
		SZ_HALF,
		SZ_WORD
	} mem_size_e;

	typedef struct packed {
		rv_op_e      op;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [31:0] imm;    // Already sign-extended for the format
		logic        rd_we;  // Never set for x0
	} rv_decoded_t;

	typedef struct packed {
		logic        valid;
		logic        is_store;
		mem_size_e   size;
		logic        is_unsigned;
		logic [31:0] addr;   // Byte address, low bits pick the lane
		logic [31:0] wdata;  // Store data, still right-aligned
		logic [4:0]  rd;
	} mem_req_t;

	// Master to slave side of AXI4-Lite
	typedef struct packed {
		logic        awvalid;
		logic [31:0] awaddr;
		logic        wvalid;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic        bready;
		logic        arvalid;
		logic [31:0] araddr;
		logic        rready;
	} axil_req_t;

	// Slave to master side of AXI4-Lite
	typedef struct packed {
		logic        awready;
		logic        wready;
		logic        bvalid;
		logic [1:0]  bresp;
		logic        arready;
		logic        rvalid;
		logic [31:0] rdata;
		logic [1:0]  rresp;
	} axil_rsp_t;

endpackage

`default_nettype wire

// File: rv_core.f
common/rv_pkg.sv
verilog/rv_decoder.sv
verilog/rv_regfile.sv
verilog/rv_execute.sv
umem/umem_axi.sv
verilog/rv_core.sv
tests/axil_mem_model.sv
tests/rv_core_tb.sv

// File: tests/axil_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module axil_mem_model (
	input  wire                    clk,
	input  wire                    mif,
	input  wire rv_pkg::axil_req_t i_axi,
	output rv_pkg::axil_rsp_t      o_axi,
	output logic                   o_log_valid,
	output logic [31:0]            o_log_addr,
	output logic [31:0]            o_log_data,
	output logic [3:0]             o_log_strb
);
	import rv_pkg::*;

	typedef enum logic [3:0] {
		M_IDLE, M_WRITE, M_BDLY, M_BWAIT,
		M_RDLY, M_RACK, M_RDDLY, M_RWAIT
	} mstate_e;

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	logic [31:0] mem [0:255];
	mstate_e     st;
	logic [15:0] lfsr;
	logic [15:0] lfsr_a;
	logic [15:0] lfsr_b;
	logic [15:0] lfsr_c;
	logic [15:0] lfsr_d;
	logic [1:0]  dly;
	logic [1:0]  dly_w;
	logic [1:0]  cnt;
	logic [1:0]  cnt_w;
	logic        aw_seen;
	logic        w_seen;
	logic [31:0] waddr_q;
	logic [31:0] wdata_q;
	logic [3:0]  wstrb_q;
	logic        awready;
	logic        wready;
	logic        bvalid;
	logic        arready;
	logic        rvalid;
	logic [31:0] rdata;

	assign lfsr_a = lfsr_step(lfsr);
	assign lfsr_b = lfsr_step(lfsr_a);
	assign lfsr_c = lfsr_step(lfsr_b);
	assign lfsr_d = lfsr_step(lfsr_c);
	assign dly    = {lfsr[0], lfsr_a[0]};  // One LFSR step per delay bit
	assign dly_w  = {lfsr_b[0], lfsr_c[0]};  // W ready gets its own delay

	initial begin
		logic [31:0] a;
		for (int i = 0; i < 256; i++) begin
			a = 32'(i) * 32'd4;
			mem[i] = (i >= 64) ? (32'hF1E2_8374 ^ (a * 32'h0001_0001)) : 32'd0;
		end
	end

	always @(posedge clk or negedge mif) begin
		if (!mif) begin
			st          <= M_IDLE;
			lfsr        <= 16'd95;
			cnt         <= 2'd0;
			cnt_w       <= 2'd0;
			aw_seen     <= 1'b0;
			w_seen      <= 1'b0;
			waddr_q     <= 32'd0;
			wdata_q     <= 32'd0;
			wstrb_q     <= 4'd0;
			awready     <= 1'b0;
			wready      <= 1'b0;
			bvalid      <= 1'b0;
			arready     <= 1'b0;
			rvalid      <= 1'b0;
			rdata       <= 32'd0;
			o_log_valid <= 1'b0;
			o_log_addr  <= 32'd0;
			o_log_data  <= 32'd0;
			o_log_strb  <= 4'd0;
		end else begin
			o_log_valid <= 1'b0;
			case (st)
				M_IDLE: begin
					if (i_axi.awvalid && i_axi.wvalid) begin
						cnt     <= dly;
						cnt_w   <= dly_w;
						aw_seen <= 1'b0;
						w_seen  <= 1'b0;
						lfsr    <= lfsr_d;
						st      <= M_WRITE;
					end else if (i_axi.arvalid) begin
						cnt  <= dly;
						lfsr <= lfsr_b;
						st   <= M_RDLY;
					end
				end
				M_WRITE: begin
					if (aw_seen && w_seen) begin  // Both channels accepted
						for (int b = 0; b < 4; b++) begin
							if (wstrb_q[b])
								mem[waddr_q[9:2]][8*b +: 8] <= wdata_q[8*b +: 8];
						end
						o_log_valid <= 1'b1;
						o_log_addr  <= waddr_q;
						o_log_data  <= wdata_q;
						o_log_strb  <= wstrb_q;
						cnt         <= dly;
						lfsr        <= lfsr_b;
						st          <= M_BDLY;
					end else begin
						if (awready && i_axi.awvalid) begin
							awready <= 1'b0;
							aw_seen <= 1'b1;
							waddr_q <= i_axi.awaddr;
						end else if (!aw_seen && !awready) begin
							if (cnt == 2'd0)
								awready <= 1'b1;
							else
								cnt <= cnt - 2'd1;
						end
						if (wready && i_axi.wvalid) begin
							wready  <= 1'b0;
							w_seen  <= 1'b1;
							wdata_q <= i_axi.wdata;
							wstrb_q <= i_axi.wstrb;
						end else if (!w_seen && !wready) begin
							if (cnt_w == 2'd0)
								wready <= 1'b1;
							else
								cnt_w <= cnt_w - 2'd1;
						end
					end
				end
				M_BDLY: begin
					if (cnt == 2'd0) begin
						bvalid <= 1'b1;
						st     <= M_BWAIT;
					end else begin
						cnt <= cnt - 2'd1;
					end
				end
				M_BWAIT: begin
					if (i_axi.bready) begin
						bvalid <= 1'b0;
						st     <= M_IDLE;
					end
				end
				M_RDLY: begin
					if (cnt == 2'd0) begin
						arready <= 1'b1;
						st      <= M_RACK;
					end else begin
						cnt <= cnt - 2'd1;
					end
				end
				M_RACK: begin
					arready <= 1'b0;
					rdata   <= mem[i_axi.araddr[9:2]];
					cnt     <= dly;
					lfsr    <= lfsr_b;
					st      <= M_RDDLY;
				end
				M_RDDLY: begin
					if (cnt == 2'd0) begin
						rvalid <= 1'b1;
						st     <= M_RWAIT;
					end else begin
						cnt <= cnt - 2'd1;
					end
				end
				default: begin
					if (i_axi.rready) begin
						rvalid <= 1'b0;
						st     <= M_IDLE;
					end
				end
			endcase
		end
	end

	always_comb begin
		o_axi.awready = awready;
		o_axi.wready  = wready;
		o_axi.bvalid  = bvalid;
		o_axi.bresp   = 2'b00;
		o_axi.arready = arready;
		o_axi.rvalid  = rvalid;
		o_axi.rdata   = rdata;
		o_axi.rresp   = 2'b00;
	end

endmodule

`default_nettype wire

// File: tests/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
		logic [3:0]  strb;
	} wr_t;

	localparam logic [31:0] OPC_IMM   = 32'h13;
	localparam logic [31:0] OPC_LOAD  = 32'h03;
	localparam logic [31:0] OPC_LUI   = 32'h37;
	localparam logic [31:0] OPC_AUIPC = 32'h17;
	localparam logic [31:0] OPC_JALR  = 32'h67;

	logic              clk;
	logic              mif;
	logic [31:0]       imem_addr;
	logic [31:0]       imem_data;
	rv_pkg::axil_req_t axi_req;
	rv_pkg::axil_rsp_t axi_rsp;
	logic              log_valid;
	logic [31:0]       log_addr;
	logic [31:0]       log_data;
	logic [3:0]        log_strb;
	logic [31:0]       prog [0:255];
	wr_t               exp_q [$];
	logic [31:0]       asm_pc;
	logic [31:0]       st_off;

	rv_core #(
		.RESET_PC (32'h0000_0000)
	) u_rv_core (
		.clk         (clk),
		.mif         (mif),
		.o_imem_addr (imem_addr),
		.i_imem_data (imem_data),
		.o_axi       (axi_req),
		.i_axi       (axi_rsp)
	);

	axil_mem_model u_axil_mem_model (
		.clk         (clk),
		.mif         (mif),
		.i_axi       (axi_req),
		.o_axi       (axi_rsp),
		.o_log_valid (log_valid),
		.o_log_addr  (log_addr),
		.o_log_data  (log_data),
		.o_log_strb  (log_strb)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	always @(negedge clk) imem_data <= prog[imem_addr[9:2]];  // Same-cycle fetch

	function automatic logic [31:0] rtype(input logic [31:0] f7, rs2, rs1, f3, rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic logic [31:0] itype(input logic [31:0] imm, rs1, f3, rd, opc);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
	endfunction

	function automatic logic [31:0] stype(input logic [31:0] imm, rs2, rs1, f3);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] btype(input logic [31:0] imm, rs2, rs1, f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
			7'b1100011};
	endfunction

	function automatic logic [31:0] utype(input logic [31:0] imm20, rd, opc);
		return {imm20[19:0], rd[4:0], opc[6:0]};
	endfunction

	function automatic logic [31:0] jtype(input logic [31:0] imm, rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic emit(input logic [31:0] word);
		prog[asm_pc[9:2]] = word;
		asm_pc += 32'd4;
	endtask

	task automatic expect_write(input logic [31:0] addr, data, input logic [3:0] strb);
		exp_q.push_back({addr, data, strb});
	endtask

	// Stores a register as a full word at the next slot above 0x200 (x10)
	task automatic store_result(input logic [31:0] rs, val);
		emit(stype(st_off, rs, 10, 2));
		expect_write(32'h200 + st_off, val, 4'b1111);
		st_off += 32'd4;
	endtask

	task automatic load_case(input logic [31:0] f3, off, val);
		emit(itype(off, 11, f3, 3, OPC_LOAD));
		store_result(3, val);
	endtask

	task automatic narrow_store(input logic [31:0] f3, k, data, input logic [3:0] strb);
		emit(stype(st_off + k, 4, 10, f3));
		expect_write(32'h200 + st_off, data, strb);
	endtask

	// Marker 1 survives only if the branch skips the marker 2 write
	task automatic branch_case(input logic [31:0] f3, rs1, rs2, input logic taken);
		emit(itype(1, 0, 0, 6, OPC_IMM));
		emit(btype(8, rs2, rs1, f3));
		emit(itype(2, 0, 0, 6, OPC_IMM));
		store_result(6, taken ? 32'd1 : 32'd2);
	endtask

	task automatic build_program();
		logic [31:0] here;
		asm_pc = 32'd0;
		st_off = 32'd0;
		for (int i = 0; i < 256; i++) begin
			prog[i] = 32'h0000_0013;
		end
		emit(itype(32'h200, 0, 0, 10, OPC_IMM));
		emit(itype(32'h100, 0, 0, 11, OPC_IMM));
		emit(itype(-5, 0, 0, 1, OPC_IMM));
		store_result(1, 32'hFFFF_FFFB);
		emit(itype(7, 0, 0, 2, OPC_IMM));
		emit(rtype(0, 2, 1, 0, 3));
		store_result(3, 32'h0000_0002);
		emit(rtype(32, 2, 1, 0, 3));
		store_result(3, 32'hFFFF_FFF4);
		emit(rtype(0, 2, 1, 2, 3));
		store_result(3, 32'h0000_0001);
		emit(rtype(0, 2, 1, 3, 3));
		store_result(3, 32'h0000_0000);
		emit(rtype(0, 2, 1, 4, 3));
		store_result(3, 32'hFFFF_FFFC);
		emit(rtype(0, 2, 1, 6, 3));
		store_result(3, 32'hFFFF_FFFF);
		emit(rtype(0, 2, 1, 7, 3));
		store_result(3, 32'h0000_0003);
		emit(rtype(0, 2, 2, 1, 3));
		store_result(3, 32'h0000_0380);
		emit(rtype(0, 2, 1, 5, 3));
		store_result(3, 32'h01FF_FFFF);
		emit(rtype(32, 2, 1, 5, 3));
		store_result(3, 32'hFFFF_FFFF);
		emit(itype(-4, 1, 2, 3, OPC_IMM));
		store_result(3, 32'h0000_0001);
		emit(itype(-1, 2, 3, 3, OPC_IMM));
		store_result(3, 32'h0000_0001);
		emit(itype(32'hF0, 1, 4, 3, OPC_IMM));
		store_result(3, 32'hFFFF_FF0B);
		emit(itype(32'h100, 2, 6, 3, OPC_IMM));
		store_result(3, 32'h0000_0107);
		emit(itype(32'h7F, 1, 7, 3, OPC_IMM));
		store_result(3, 32'h0000_007B);
		emit(itype(4, 1, 1, 3, OPC_IMM));
		store_result(3, 32'hFFFF_FFB0);
		emit(itype(28, 1, 5, 3, OPC_IMM));
		store_result(3, 32'h0000_000F);
		emit(itype(32'h401, 1, 5, 3, OPC_IMM));
		store_result(3, 32'hFFFF_FFFD);
		emit(utype(32'h12345, 3, OPC_LUI));
		store_result(3, 32'h1234_5000);
		here = asm_pc;
		emit(utype(1, 3, OPC_AUIPC));
		store_result(3, here + 32'h1000);
		// Word at 0x100 holds F0E28274
		load_case(0, 0, 32'h0000_0074);
		load_case(0, 1, 32'hFFFF_FF82);
		load_case(0, 2, 32'hFFFF_FFE2);
		load_case(0, 3, 32'hFFFF_FFF0);
		load_case(4, 1, 32'h0000_0082);
		load_case(4, 3, 32'h0000_00F0);
		load_case(1, 0, 32'hFFFF_8274);
		load_case(1, 2, 32'hFFFF_F0E2);
		load_case(5, 0, 32'h0000_8274);
		load_case(5, 2, 32'h0000_F0E2);
		load_case(2, 0, 32'hF0E2_8274);
		emit(utype(32'h11223, 4, OPC_LUI));
		emit(itype(32'h344, 4, 0, 4, OPC_IMM));
		narrow_store(0, 0, 32'h0000_0044, 4'b0001);
		narrow_store(0, 1, 32'h0000_4400, 4'b0010);
		narrow_store(0, 2, 32'h0044_0000, 4'b0100);
		narrow_store(0, 3, 32'h4400_0000, 4'b1000);
		narrow_store(1, 0, 32'h0000_3344, 4'b0011);
		narrow_store(1, 2, 32'h3344_0000, 4'b1100);
		st_off += 32'd4;
		branch_case(0, 1, 1, 1'b1);
		branch_case(0, 1, 2, 1'b0);
		branch_case(1, 1, 2, 1'b1);
		branch_case(1, 1, 1, 1'b0);
		branch_case(4, 1, 2, 1'b1);
		branch_case(4, 2, 1, 1'b0);
		branch_case(5, 2, 1, 1'b1);
		branch_case(5, 1, 2, 1'b0);
		branch_case(6, 2, 1, 1'b1);
		branch_case(6, 1, 2, 1'b0);
		branch_case(7, 1, 2, 1'b1);
		branch_case(7, 2, 1, 1'b0);
		here = asm_pc;
		emit(jtype(8, 7));
		emit(itype(0, 0, 0, 7, OPC_IMM));  // Skipped, would clear the link
		store_result(7, here + 32'd4);
		here = asm_pc;
		emit(utype(0, 8, OPC_AUIPC));
		emit(itype(17, 8, 0, 9, OPC_JALR));  // Odd offset, bit 0 is dropped
		emit(itype(0, 0, 0, 9, OPC_IMM));
		emit(itype(0, 0, 0, 9, OPC_IMM));
		store_result(9, here + 32'd8);
		emit(jtype(0, 0));
	endtask

	task automatic check_idle_outputs();
		assert (imem_addr == 32'h0000_0000) else
			abort_run($sformatf("FAIL o_imem_addr: got %08h expected %08h", imem_addr, 0));
		assert (!axi_req.awvalid && !axi_req.wvalid && !axi_req.bready &&
			!axi_req.arvalid && !axi_req.rready) else
			abort_run("An AXI valid or ready output was high around reset");
	endtask

	task automatic wait_write(input int idx);
		int cnt;
		cnt = 0;
		@(negedge clk);
		while (!log_valid) begin
			cnt++;
			if (cnt > 500)
				abort_run($sformatf("Timed out waiting for write %0d to address %08h",
					idx, exp_q[idx].addr));
			@(negedge clk);
		end
	endtask

	initial begin
		mif       = 1'b0;
		imem_data = 32'h0000_0013;
		build_program();
		repeat (16) begin
			@(negedge clk);
			check_idle_outputs();
		end
		mif = 1'b1;
		#1;
		check_idle_outputs();
		foreach (exp_q[i]) begin
			wait_write(i);
			assert (log_addr == exp_q[i].addr) else
				abort_run($sformatf("FAIL awaddr: got %08h expected %08h",
					log_addr, exp_q[i].addr));
			assert (log_data == exp_q[i].data) else
				abort_run($sformatf("FAIL wdata: got %08h expected %08h",
					log_data, exp_q[i].data));
			assert (log_strb == exp_q[i].strb) else
				abort_run($sformatf("FAIL wstrb: got %h expected %h",
					log_strb, exp_q[i].strb));
		end
		repeat (50) begin  // Program now spins on its final JAL
			@(negedge clk);
			assert (!log_valid) else
				abort_run("An extra write appeared after the last expected one");
		end
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: umem/umem_axi.sv
`timescale 1ns/1ps
`default_nettype none

module umem_axi (
	input  wire                    clk,
	input  wire                    mif,
	input  wire rv_pkg::mem_req_t  i_req,
	output logic                   o_busy,
	output logic                   o_ld_we,
	output logic [4:0]             o_ld_rd,
	output logic [31:0]            o_ld_data,
	output rv_pkg::axil_req_t      o_axi,
	input  wire rv_pkg::axil_rsp_t i_axi
);
	import rv_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		WRITE,
		WRESP,
		READ,
		RRESP
	} state_e;

	state_e      state;
	logic        aw_pend;
	logic        w_pend;
	logic        aw_left;
	logic        w_left;
	logic        resp_done;
	logic [31:0] addr_q;
	logic [31:0] wdata_q;
	logic [3:0]  wstrb_q;
	mem_size_e   size_q;
	logic        unsigned_q;
	logic [4:0]  rd_q;
	logic [31:0] lane_data;
	logic [3:0]  lane_strb;
	logic [31:0] rdata_lane;

	// Trim store data to its size before moving it onto the addressed lane
	always_comb begin
		case (i_req.size)
			SZ_BYTE: begin
				lane_data = {24'd0, i_req.wdata[7:0]};
				lane_strb = 4'b0001;
			end
			SZ_HALF: begin
				lane_data = {16'd0, i_req.wdata[15:0]};
				lane_strb = 4'b0011;
			end
			default: begin
				lane_data = i_req.wdata;
				lane_strb = 4'b1111;
			end
		endcase
	end

	assign aw_left   = aw_pend & ~i_axi.awready;  // Still waiting on AW after this edge
	assign w_left    = w_pend & ~i_axi.wready;
	assign resp_done = ((state == WRESP) & i_axi.bvalid) | ((state == RRESP) & i_axi.rvalid);

	always_ff @(posedge clk or negedge mif) begin
		if (!mif) begin
			state   <= IDLE;
			aw_pend <= 1'b0;
			w_pend  <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (i_req.valid && i_req.is_store) begin
						state   <= WRITE;
						aw_pend <= 1'b1;
						w_pend  <= 1'b1;
					end else if (i_req.valid) begin
						state <= READ;
					end
				end
				WRITE: begin
					aw_pend <= aw_left;
					w_pend  <= w_left;
					if (!aw_left && !w_left)
						state <= WRESP;
				end
				READ:    state <= i_axi.arready ? RRESP : READ;
				default: state <= resp_done ? IDLE : state;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && i_req.valid) begin
			addr_q     <= i_req.addr;
			wdata_q    <= lane_data << {i_req.addr[1:0], 3'b000};
			wstrb_q    <= lane_strb << i_req.addr[1:0];
			size_q     <= i_req.size;
			unsigned_q <= i_req.is_unsigned;
			rd_q       <= i_req.rd;
		end
	end

	assign rdata_lane = i_axi.rdata >> {addr_q[1:0], 3'b000};

	always_comb begin
		case (size_q)
			SZ_BYTE: o_ld_data = {{24{~unsigned_q & rdata_lane[7]}}, rdata_lane[7:0]};
			SZ_HALF: o_ld_data = {{16{~unsigned_q & rdata_lane[15]}}, rdata_lane[15:0]};
			default: o_ld_data = rdata_lane;
		endcase
	end

	assign o_ld_we = (state == RRESP) & i_axi.rvalid;
	assign o_ld_rd = rd_q;
	assign o_busy  = (state == IDLE) ? i_req.valid : ~resp_done;  // Low in the response cycle

	always_comb begin
		o_axi.awvalid = aw_pend;
		o_axi.awaddr  = {addr_q[31:2], 2'b00};
		o_axi.wvalid  = w_pend;
		o_axi.wdata   = wdata_q;
		o_axi.wstrb   = wstrb_q;
		o_axi.bready  = (state == WRESP);
		o_axi.arvalid = (state == READ);
		o_axi.araddr  = {addr_q[31:2], 2'b00};
		o_axi.rready  = (state == RRESP);
	end

endmodule

`default_nettype wire

// File: verilog/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
	parameter logic [31:0] RESET_PC = 32'h8000_0000
) (
	input  wire                    clk,
	input  wire                    mif,
	output logic [31:0]            o_imem_addr,
	input  wire [31:0]             i_imem_data,
	output rv_pkg::axil_req_t      o_axi,
	input  wire rv_pkg::axil_rsp_t i_axi
);
	import rv_pkg::*;

	rv_decoded_t dec;
	mem_req_t    mem_req;
	logic [31:0] rs1_data;
	logic [31:0] rs2_data;
	logic [31:0] exe_result;
	logic        exe_we;
	logic        stall;
	logic        mem_busy;
	logic        ld_we;
	logic [4:0]  ld_rd;
	logic [31:0] ld_data;
	logic        wr_we;
	logic [4:0]  wr_rd;
	logic [31:0] wr_data;

	rv_decoder u_rv_decoder (
		.i_instr (i_imem_data),  // Fetch returns the word in the same cycle
		.o_dec   (dec)
	);

	rv_regfile u_rv_regfile (
		.clk        (clk),
		.mif        (mif),
		.i_rs1      (dec.rs1),
		.i_rs2      (dec.rs2),
		.o_rs1_data (rs1_data),
		.o_rs2_data (rs2_data),
		.i_we       (wr_we),
		.i_rd       (wr_rd),
		.i_wdata    (wr_data)
	);

	rv_execute #(
		.RESET_PC (RESET_PC)
	) u_rv_execute (
		.clk        (clk),
		.mif        (mif),
		.i_dec      (dec),
		.i_rs1_data (rs1_data),
		.i_rs2_data (rs2_data),
		.i_stall    (stall),
		.o_pc       (o_imem_addr),
		.o_result   (exe_result),
		.o_reg_we   (exe_we),
		.o_mem_req  (mem_req)
	);

	umem_axi u_umem_axi (
		.clk       (clk),
		.mif       (mif),
		.i_req     (mem_req),
		.o_busy    (mem_busy),
		.o_ld_we   (ld_we),
		.o_ld_rd   (ld_rd),
		.o_ld_data (ld_data),
		.o_axi     (o_axi),
		.i_axi     (i_axi)
	);

	// Hold PC and instruction until the memory response handshake
	assign stall = mem_req.valid & mem_busy;

	assign wr_we   = ld_we | exe_we;  // Never both in one cycle
	assign wr_rd   = ld_we ? ld_rd : dec.rd;
	assign wr_data = ld_we ? ld_data : exe_result;

endmodule

`default_nettype wire

// File: verilog/rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
	input  wire [31:0]          i_instr,
	output rv_pkg::rv_decoded_t o_dec
);
	import rv_pkg::*;

	typedef enum logic [6:0] {
		OPC_LOAD   = 7'b0000011,
		OPC_FENCE  = 7'b0001111,
		OPC_OPIMM  = 7'b0010011,
		OPC_AUIPC  = 7'b0010111,
		OPC_STORE  = 7'b0100011,
		OPC_OP     = 7'b0110011,
		OPC_LUI    = 7'b0110111,
		OPC_BRANCH = 7'b1100011,
		OPC_JALR   = 7'b1100111,
		OPC_JAL    = 7'b1101111,
		OPC_SYSTEM = 7'b1110011
	} opcode_e;

	opcode_e     opcode;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;
	logic [31:0] imm;
	logic        writes_rd;
	rv_op_e      op;

	assign opcode = opcode_e'(i_instr[6:0]);
	assign funct3 = i_instr[14:12];
	assign funct7 = i_instr[31:25];

	assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
	assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
	assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
		i_instr[11:8], 1'b0};  // Offsets are in half-words, bit 0 is implicit
	assign imm_u = {i_instr[31:12], 12'd0};
	assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
		i_instr[30:21], 1'b0};

	always_comb begin
		op = OP_NOP;  // Anything not matched below runs as a no-op
		case (opcode)
			OPC_LUI:   op = OP_LUI;
			OPC_AUIPC: op = OP_AUIPC;
			OPC_JAL:   op = OP_JAL;
			OPC_JALR:  op = (funct3 == 3'b000) ? OP_JALR : OP_NOP;
			OPC_FENCE: op = (funct3 == 3'b000) ? OP_FENCE : OP_NOP;
			OPC_BRANCH: begin
				case (funct3)
					3'b000:  op = OP_BEQ;
					3'b001:  op = OP_BNE;
					3'b100:  op = OP_BLT;
					3'b101:  op = OP_BGE;
					3'b110:  op = OP_BLTU;
					3'b111:  op = OP_BGEU;
					default: op = OP_NOP;
				endcase
			end
			OPC_LOAD: begin
				case (funct3)
					3'b000:  op = OP_LB;
					3'b001:  op = OP_LH;
					3'b010:  op = OP_LW;
					3'b100:  op = OP_LBU;
					3'b101:  op = OP_LHU;
					default: op = OP_NOP;
				endcase
			end
			OPC_STORE: begin
				case (funct3)
					3'b000:  op = OP_SB;
					3'b001:  op = OP_SH;
					3'b010:  op = OP_SW;
					default: op = OP_NOP;
				endcase
			end
			OPC_OPIMM: begin
				case (funct3)
					3'b000:  op = OP_ADDI;
					3'b010:  op = OP_SLTI;
					3'b011:  op = OP_SLTIU;
					3'b100:  op = OP_XORI;
					3'b110:  op = OP_ORI;
					3'b111:  op = OP_ANDI;
					3'b001:  op = (funct7 == 7'b0000000) ? OP_SLLI : OP_NOP;
					default: begin
						if (funct7 == 7'b0000000)
							op = OP_SRLI;
						else if (funct7 == 7'b0100000)
							op = OP_SRAI;
					end
				endcase
			end
			OPC_OP: begin
				case ({funct7, funct3})
					10'b0000000_000: op = OP_ADD;
					10'b0100000_000: op = OP_SUB;
					10'b0000000_001: op = OP_SLL;
					10'b0000000_010: op = OP_SLT;
					10'b0000000_011: op = OP_SLTU;
					10'b0000000_100: op = OP_XOR;
					10'b0000000_101: op = OP_SRL;
					10'b0100000_101: op = OP_SRA;
					10'b0000000_110: op = OP_OR;
					10'b0000000_111: op = OP_AND;
					default:         op = OP_NOP;
				endcase
			end
			OPC_SYSTEM: begin
				if (i_instr[31:7] == 25'd0)
					op = OP_ECALL;
				else if (i_instr[31:7] == {12'h001, 13'd0})
					op = OP_EBREAK;
			end
			default: op = OP_NOP;
		endcase
	end

	always_comb begin
		case (opcode)
			OPC_STORE:          imm = imm_s;
			OPC_BRANCH:         imm = imm_b;
			OPC_LUI, OPC_AUIPC: imm = imm_u;
			OPC_JAL:            imm = imm_j;
			default:            imm = imm_i;  // Also carries shamt in bits 4:0
		endcase
	end

	assign writes_rd = !(op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
		OP_SB, OP_SH, OP_SW, OP_FENCE, OP_ECALL, OP_EBREAK, OP_NOP});

	always_comb begin
		o_dec.op    = op;
		o_dec.rd    = i_instr[11:7];
		o_dec.rs1   = i_instr[19:15];
		o_dec.rs2   = i_instr[24:20];
		o_dec.imm   = imm;
		o_dec.rd_we = writes_rd && (i_instr[11:7] != 5'd0);
	end

endmodule

`default_nettype wire

// File: verilog/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute #(
	parameter logic [31:0] RESET_PC = 32'h8000_0000
) (
	input  wire                 clk,
	input  wire                 mif,
	input  wire rv_pkg::rv_decoded_t i_dec,
	input  wire [31:0]          i_rs1_data,
	input  wire [31:0]          i_rs2_data,
	input  wire                 i_stall,
	output logic [31:0]         o_pc,
	output logic [31:0]         o_result,
	output logic                o_reg_we,
	output rv_pkg::mem_req_t    o_mem_req
);
	import rv_pkg::*;

	logic [31:0] pc;
	logic [31:0] pc_plus4;
	logic [31:0] pc_plus_imm;
	logic [31:0] rs1_plus_imm;
	logic [31:0] op_b;
	logic [31:0] target;
	logic        take;
	logic        is_load;
	logic        is_store;

	assign pc_plus4     = pc + 32'd4;
	assign pc_plus_imm  = pc + i_dec.imm;
	assign rs1_plus_imm = i_rs1_data + i_dec.imm;  // Load/store address and JALR target

	// Register-register ops take rs2, all others the immediate
	assign op_b = (i_dec.op inside {OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR,
		OP_SRL, OP_SRA, OP_OR, OP_AND}) ? i_rs2_data : i_dec.imm;

	always_comb begin
		case (i_dec.op)
			OP_LUI:            o_result = i_dec.imm;
			OP_AUIPC:          o_result = pc_plus_imm;
			OP_JAL, OP_JALR:   o_result = pc_plus4;  // Link address
			OP_ADD, OP_ADDI:   o_result = i_rs1_data + op_b;
			OP_SUB:            o_result = i_rs1_data - op_b;
			OP_SLT, OP_SLTI:   o_result = {31'd0, $signed(i_rs1_data) < $signed(op_b)};
			OP_SLTU, OP_SLTIU: o_result = {31'd0, i_rs1_data < op_b};
			OP_XOR, OP_XORI:   o_result = i_rs1_data ^ op_b;
			OP_OR, OP_ORI:     o_result = i_rs1_data | op_b;
			OP_AND, OP_ANDI:   o_result = i_rs1_data & op_b;
			OP_SLL, OP_SLLI:   o_result = i_rs1_data << op_b[4:0];
			OP_SRL, OP_SRLI:   o_result = i_rs1_data >> op_b[4:0];
			OP_SRA, OP_SRAI:   o_result = $signed(i_rs1_data) >>> op_b[4:0];
			default:           o_result = 32'd0;
		endcase
	end

	always_comb begin
		case (i_dec.op)
			OP_JAL, OP_JALR: take = 1'b1;
			OP_BEQ:          take = (i_rs1_data == i_rs2_data);
			OP_BNE:          take = (i_rs1_data != i_rs2_data);
			OP_BLT:          take = ($signed(i_rs1_data) < $signed(i_rs2_data));
			OP_BGE:          take = ($signed(i_rs1_data) >= $signed(i_rs2_data));
			OP_BLTU:         take = (i_rs1_data < i_rs2_data);
			OP_BGEU:         take = (i_rs1_data >= i_rs2_data);
			default:         take = 1'b0;
		endcase
	end

	assign target = (i_dec.op == OP_JALR) ? {rs1_plus_imm[31:1], 1'b0} : pc_plus_imm;

	always_ff @(posedge clk or negedge mif) begin
		if (!mif)
			pc <= RESET_PC;
		else if (!i_stall)
			pc <= take ? target : pc_plus4;
	end

	assign is_load  = i_dec.op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
	assign is_store = i_dec.op inside {OP_SB, OP_SH, OP_SW};

	always_comb begin
		o_mem_req.valid    = is_load | is_store;
		o_mem_req.is_store = is_store;
		case (i_dec.op)
			OP_LB, OP_LBU, OP_SB: o_mem_req.size = SZ_BYTE;
			OP_LH, OP_LHU, OP_SH: o_mem_req.size = SZ_HALF;
			default:              o_mem_req.size = SZ_WORD;
		endcase
		o_mem_req.is_unsigned = i_dec.op inside {OP_LBU, OP_LHU};
		o_mem_req.addr        = rs1_plus_imm;
		o_mem_req.wdata       = i_rs2_data;
		o_mem_req.rd          = i_dec.rd;
	end

	assign o_pc     = pc;
	assign o_reg_we = i_dec.rd_we & ~o_mem_req.valid & ~i_stall;  // Loads write back via umem

endmodule

`default_nettype wire

// File: verilog/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
	input  wire        clk,
	input  wire        mif,
	input  wire [4:0]  i_rs1,
	input  wire [4:0]  i_rs2,
	output logic [31:0] o_rs1_data,
	output logic [31:0] o_rs2_data,
	input  wire        i_we,
	input  wire [4:0]  i_rd,
	input  wire [31:0] i_wdata
);

	logic [31:0] regs [31:1];  // x0 has no storage

	always_ff @(posedge clk or negedge mif) begin
		if (!mif) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= 32'd0;
			end
		end else if (i_we && (i_rd != 5'd0)) begin
			regs[i_rd] <= i_wdata;
		end
	end

	assign o_rs1_data = (i_rs1 == 5'd0) ? 32'd0 : regs[i_rs1];
	assign o_rs2_data = (i_rs2 == 5'd0) ? 32'd0 : regs[i_rs2];

endmodule

`default_nettype wire
